// File: aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder (
  input  logic                aluOpE,
  input  armCtrlPkg::aluCtrlT aluCtrlE,
  input  logic                carryIn,
  output armCtrlPkg::aluOpT   aluOperationE,
  output logic [2:0]          cvUpdateE,
  output logic                invertBE,
  output logic                reverseInputsE,
  output logic                aluCarryE,
  output logic                doNotWriteRegE
);
  import armCtrlPkg::*;

  logic arith;  // Opcode uses the adder

  always_comb begin
    aluOperationE = opAdd;  // Address and branch arithmetic
    invertBE = 1'b0;
    reverseInputsE = 1'b0;
    aluCarryE = 1'b0;
    arith = 1'b0;
    if (aluOpE) begin
      case (aluCtrlE)
        ctrlAnd, ctrlTst: aluOperationE = opAnd;
        ctrlEor, ctrlTeq: aluOperationE = opXor;
        ctrlOrr:          aluOperationE = opOr;
        ctrlMov:          aluOperationE = opPass;
        ctrlBic: begin
          aluOperationE = opAnd;
          invertBE = 1'b1;
        end
        ctrlMvn: begin
          aluOperationE = opPass;
          invertBE = 1'b1;
        end
        ctrlAdd, ctrlCmn: arith = 1'b1;
        ctrlAdc: begin
          arith = 1'b1;
          aluCarryE = carryIn;
        end
        ctrlSub, ctrlCmp, ctrlSbc: begin
          // A + ~B + 1 or A + ~B + C
          arith = 1'b1;
          invertBE = 1'b1;
          aluCarryE = (aluCtrlE == ctrlSbc) ? carryIn : 1'b1;
        end
        default: begin
          arith = 1'b1;  // RSB and RSC swap operands
          reverseInputsE = 1'b1;
          invertBE = 1'b1;
          aluCarryE = (aluCtrlE == ctrlRsc) ? carryIn : 1'b1;
        end
      endcase
    end
  end

  assign doNotWriteRegE = aluOpE && (aluCtrlE inside {ctrlTst, ctrlTeq, ctrlCmp, ctrlCmn});

  // Mask bits are {NZ, C, V}
  assign cvUpdateE = !aluOpE ? 3'b000 : (arith ? 3'b111 : 3'b100);

endmodule

// File: armControlTop.sv
`timescale 1ns/1ps

module armControlTop (
  input  logic              clk,
  input  logic              reset,
  input  armCtrlPkg::instrT instrD,
  input  armCtrlPkg::flagsT flagsE,
  input  logic              ldUseMatch,
  input  logic              memWait,
  output logic [1:0]        regSrcD,
  output logic [1:0]        immSrcD,
  output logic              aluSrcE,
  output logic              branchTakenE,
  output logic              memtoRegE,
  output logic              multEnableE,
  output armCtrlPkg::aluOpT aluOperationE,
  output logic              invertBE,
  output logic              reverseInputsE,
  output logic              aluCarryE,
  output logic              memWriteM,
  output logic              regWriteM,
  output logic              memtoRegM,
  output logic              regWriteW,
  output logic              memtoRegW,
  output logic              pcSrcW,
  output logic              pcWrPendingF,
  output logic              stallF,
  output logic              stallD,
  output logic              stallE,
  output logic              stallM,
  output logic              stallW,
  output logic              flushD,
  output logic              flushE,
  output logic              flushW
);

  decodeIf decBus ();

  mainDecoder mainDec (
    .instrD,
    .dec(decBus.decoder)
  );

  controller pipeCtrl (
    .clk, .reset, .dec(decBus.pipeline), .instrD, .flagsE,
    .stallE, .stallM, .stallW, .flushE, .flushW,
    .aluSrcE, .branchTakenE, .memtoRegE, .multEnableE, .aluOperationE,
    .invertBE, .reverseInputsE, .aluCarryE,
    .memWriteM, .regWriteM, .memtoRegM,
    .regWriteW, .memtoRegW, .pcSrcW, .pcWrPendingF
  );

  hazardUnit hazard (
    .ldUseMatch, .memtoRegE, .branchTakenE, .pcWrPendingF, .memWait,
    .stallF, .stallD, .stallE, .stallM, .stallW,
    .flushD, .flushE, .flushW
  );

  // Datapath read port and immediate selects
  assign regSrcD = decBus.regSrc;
  assign immSrcD = decBus.immSrc;

endmodule

// File: armCtrlPkg.sv
package armCtrlPkg;

  typedef logic [31:0] instrT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Condition field in bits 31:28
  typedef enum logic [3:0] {
    condEQ = 4'h0, condNE = 4'h1, condCS = 4'h2, condCC = 4'h3,
    condMI = 4'h4, condPL = 4'h5, condVS = 4'h6, condVC = 4'h7,
    condHI = 4'h8, condLS = 4'h9, condGE = 4'ha, condLT = 4'hb,
    condGT = 4'hc, condLE = 4'hd, condAL = 4'he, condNV = 4'hf
  } condT;

  // Data-processing opcode in bits 24:21
  typedef enum logic [3:0] {
    ctrlAnd = 4'h0, ctrlEor = 4'h1, ctrlSub = 4'h2, ctrlRsb = 4'h3,
    ctrlAdd = 4'h4, ctrlAdc = 4'h5, ctrlSbc = 4'h6, ctrlRsc = 4'h7,
    ctrlTst = 4'h8, ctrlTeq = 4'h9, ctrlCmp = 4'ha, ctrlCmn = 4'hb,
    ctrlOrr = 4'hc, ctrlMov = 4'hd, ctrlBic = 4'he, ctrlMvn = 4'hf
  } aluCtrlT;

  typedef enum logic [2:0] {
    opAnd  = 3'd0,
    opOr   = 3'd1,
    opXor  = 3'd2,
    opAdd  = 3'd3,
    opPass = 3'd4  // Operand B straight through
  } aluOpT;

  typedef struct packed {
    logic       aluSrc;     // Immediate operand B
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluOp;      // ALU decoder active
    logic       multSelect;
    logic       pcSrc;      // Instruction writes r15
    logic [1:0] flagWrite;  // {NZ, CV}
    aluCtrlT    aluCtrl;
  } ctrlBundleT;

  localparam logic [3:0] pcReg = 4'd15;
  localparam logic [3:0] multPattern = 4'b1001;  // Bits 7:4 of MUL/MLA

  // Offset direction for loads and stores
  localparam aluCtrlT addCtrl = ctrlAdd;
  localparam aluCtrlT subCtrl = ctrlSub;

endpackage

// File: conditionUnit.sv
`timescale 1ns/1ps

module conditionUnit (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  input  armCtrlPkg::condT  condE,
  input  armCtrlPkg::flagsT flagsE,
  input  logic [1:0]        flagWriteE,
  input  logic [2:0]        updateMask,
  output logic              condExE,
  output armCtrlPkg::flagsT flagsPrevE
);
  import armCtrlPkg::*;

  flagsT flags;  // Stored NZCV
  logic  ge;

  assign ge = (flags.n == flags.v);  // Signed greater or equal

  always_comb begin
    case (condE)
      condEQ:  condExE = flags.z;
      condNE:  condExE = ~flags.z;
      condCS:  condExE = flags.c;
      condCC:  condExE = ~flags.c;
      condMI:  condExE = flags.n;
      condPL:  condExE = ~flags.n;
      condVS:  condExE = flags.v;
      condVC:  condExE = ~flags.v;
      condHI:  condExE = flags.c & ~flags.z;
      condLS:  condExE = ~flags.c | flags.z;
      condGE:  condExE = ge;
      condLT:  condExE = ~ge;
      condGT:  condExE = ~flags.z & ge;
      condLE:  condExE = flags.z | ~ge;
      condAL:  condExE = 1'b1;
      default: condExE = 1'b0;  // NV never executes
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (enable && condExE) begin
      if (flagWriteE[1] && updateMask[2]) begin
        flags.n <= flagsE.n;
        flags.z <= flagsE.z;
      end
      if (flagWriteE[0] && updateMask[1]) begin
        flags.c <= flagsE.c;
      end
      if (flagWriteE[0] && updateMask[0]) begin
        flags.v <= flagsE.v;
      end
    end
  end

  assign flagsPrevE = flags;

  // Flags hold through a pipeline freeze
  assert property (@(posedge clk) disable iff (reset) !enable |=> $stable(flags));

endmodule

// File: controller.sv
`timescale 1ns/1ps

module controller (
  input  logic              clk,
  input  logic              reset,
  decodeIf.pipeline         dec,
  input  armCtrlPkg::instrT instrD,
  input  armCtrlPkg::flagsT flagsE,
  input  logic              stallE,
  input  logic              stallM,
  input  logic              stallW,
  input  logic              flushE,
  input  logic              flushW,
  output logic              aluSrcE,
  output logic              branchTakenE,
  output logic              memtoRegE,
  output logic              multEnableE,
  output armCtrlPkg::aluOpT aluOperationE,
  output logic              invertBE,
  output logic              reverseInputsE,
  output logic              aluCarryE,
  output logic              memWriteM,
  output logic              regWriteM,
  output logic              memtoRegM,
  output logic              regWriteW,
  output logic              memtoRegW,
  output logic              pcSrcW,
  output logic              pcWrPendingF
);
  import armCtrlPkg::*;

  ctrlBundleT ctrlE;
  condT       condE;
  logic       multD;
  logic       multE;
  logic       condExE;
  logic       doNotWriteRegE;
  logic [2:0] cvUpdateE;
  flagsT      flagsPrevE;
  logic       regWriteGatedE;
  logic       memWriteGatedE;
  logic       pcSrcGatedE;
  logic       pcSrcM;

  // Long multiplies set bit 23 and are not enabled here
  assign multD = dec.ctrl.multSelect & ~dec.multControl[2];

  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      ctrlE <= '0;
      condE <= condEQ;
      multE <= 1'b0;
    end else if (!stallE) begin
      ctrlE <= dec.ctrl;
      condE <= condT'(instrD[31:28]);
      multE <= multD;
    end
  end

  aluDecoder aluDec (
    .aluOpE(ctrlE.aluOp),
    .aluCtrlE(ctrlE.aluCtrl),
    .carryIn(flagsPrevE.c),
    .aluOperationE,
    .cvUpdateE,
    .invertBE,
    .reverseInputsE,
    .aluCarryE,
    .doNotWriteRegE
  );

  conditionUnit condUnit (
    .clk,
    .reset,
    .enable(~stallE),
    .condE,
    .flagsE,
    .flagWriteE(ctrlE.flagWrite),
    .updateMask(cvUpdateE),
    .condExE,
    .flagsPrevE
  );

  assign aluSrcE = ctrlE.aluSrc;
  assign memtoRegE = ctrlE.memtoReg;
  assign multEnableE = multE & condExE;
  assign branchTakenE = ctrlE.branch & condExE;

  // Compares set flags only
  assign regWriteGatedE = ctrlE.regWrite & condExE & ~doNotWriteRegE;
  assign memWriteGatedE = ctrlE.memWrite & condExE;
  assign pcSrcGatedE = ctrlE.pcSrc & condExE;

  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteM <= 1'b0;
      regWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM <= 1'b0;
    end else if (!stallM) begin
      memWriteM <= memWriteGatedE;
      regWriteM <= regWriteGatedE;
      memtoRegM <= ctrlE.memtoReg;
      pcSrcM <= pcSrcGatedE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW <= 1'b0;
    end else if (!stallW) begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW <= pcSrcM;
    end
  end

  assign pcWrPendingF = dec.ctrl.pcSrc | ctrlE.pcSrc | pcSrcM;  // Hold fetch until r15 lands

  // Decoder never pairs a store with a register write
  assert property (@(posedge clk) disable iff (reset) !(memWriteM && regWriteM));

  assert property (@(posedge clk) reset |=>
    !(aluSrcE || branchTakenE || memtoRegE || multEnableE || memWriteM ||
      regWriteM || memtoRegM || regWriteW || memtoRegW || pcSrcW));

endmodule

// File: controllerTb.sv
`timescale 1ns/1ps

module controllerTb;
  import armCtrlPkg::*;

  // Expected control of one instruction in a stage
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic       load;
    logic       imm;      // Operand B from the immediate
    logic       mult;     // Short multiply
    logic       alu;      // Opcode drives the ALU
    logic [3:0] op;
    logic [1:0] flagUpd;  // {NZ, CV}
    logic [3:0] cond;
  } stageT;

  localparam int testInstrCount = 200;
  localparam instrT nopInstr = 32'hf000_0000;  // NV condition, never executes

  logic clk = 1'b0;
  logic reset;
  instrT instrD;
  flagsT flagsE;
  logic ldUseMatch, memWait;
  logic [1:0] regSrcD, immSrcD;
  logic aluSrcE, branchTakenE, memtoRegE, multEnableE;
  aluOpT aluOperationE;
  logic invertBE, reverseInputsE, aluCarryE;
  logic memWriteM, regWriteM, memtoRegM, regWriteW, memtoRegW, pcSrcW, pcWrPendingF;
  logic stallF, stallD, stallE, stallM, stallW, flushD, flushE, flushW;

  int errCount = 0;
  int testsRun = 0;
  int testsFailed = 0;

  stageT mE, mM, mW, dNow;
  flagsT refFlags;
  logic exE, expBranch, expLdStall, expFlushE, expStallD, expPending, expFlushD;
  logic expStallF;
  logic [5:0] expAlu;
  logic [3:0] expSelD;

  armControlTop i_dut (.*);

  always #5 clk = ~clk;

  // Condition table of the architecture
  function automatic logic condPasses(logic [3:0] c, flagsT f);
    case (c)
      4'h0: return f.z;
      4'h1: return !f.z;
      4'h2: return f.c;
      4'h3: return !f.c;
      4'h4: return f.n;
      4'h5: return !f.n;
      4'h6: return f.v;
      4'h7: return !f.v;
      4'h8: return f.c && !f.z;
      4'h9: return !f.c || f.z;
      4'ha: return f.n == f.v;
      4'hb: return f.n != f.v;
      4'hc: return !f.z && (f.n == f.v);
      4'hd: return f.z || (f.n != f.v);
      4'he: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic stageT refDecode(instrT i);
    stageT s;
    logic logical;
    logic mulForm;
    s = '0;
    s.cond = i[31:28];
    logical = i[24:21] inside {4'h0, 4'h1, 4'h8, 4'h9, 4'hc, 4'hd, 4'he, 4'hf};
    mulForm = !i[25] && (i[7:4] == 4'b1001);
    case (i[27:26])
      2'b00: begin
        s.regWrite = !(i[24:21] inside {4'h8, 4'h9, 4'ha, 4'hb});  // Compares
        s.flagUpd = i[20] ? (logical ? 2'b10 : 2'b11) : 2'b00;
        s.pcSrc = mulForm ? (i[19:16] == 4'd15) : (i[15:12] == 4'd15);
        s.imm = i[25];
        s.mult = mulForm && !i[23];
        s.alu = 1'b1;
        s.op = i[24:21];
      end
      2'b01: begin
        s.load = i[20];
        s.regWrite = i[20];
        s.memWrite = !i[20];
        s.pcSrc = i[20] && (i[15:12] == 4'd15);
        s.imm = !i[25];
        s.alu = 1'b1;
        s.op = i[23] ? 4'h4 : 4'h2;  // Offset up or down
      end
      2'b10: begin
        s.branch = i[25];
        s.pcSrc = i[25];
        s.imm = i[25];
      end
      default: begin
      end
    endcase
    return s;
  endfunction

  // {class, invert B, reverse, carry in} of the ARM operations
  function automatic logic [5:0] aluExpect(stageT s, logic cin);
    logic [2:0] kind;
    logic inv;
    logic rev;
    logic cy;
    kind = 3'd3;
    inv = 1'b0;
    rev = 1'b0;
    cy = 1'b0;
    if (s.alu) begin
      case (s.op)
        4'h0, 4'h8: kind = 3'd0;
        4'h1, 4'h9: kind = 3'd2;
        4'hc: kind = 3'd1;
        4'hd: kind = 3'd4;
        4'he: begin
          kind = 3'd0;
          inv = 1'b1;
        end
        4'hf: begin
          kind = 3'd4;
          inv = 1'b1;
        end
        4'h5: cy = cin;
        4'h2, 4'ha: begin
          inv = 1'b1;  // A - B
          cy = 1'b1;
        end
        4'h6: begin
          inv = 1'b1;
          cy = cin;
        end
        4'h3: begin
          inv = 1'b1;
          rev = 1'b1;
          cy = 1'b1;
        end
        4'h7: begin
          inv = 1'b1;
          rev = 1'b1;
          cy = cin;
        end
        default: begin
        end
      endcase
    end
    return {kind, inv, rev, cy};
  endfunction

  // {regSrc, immSrc} of the D-stage instruction
  function automatic logic [3:0] dSelects(instrT i);
    if (i[27:26] == 2'b01) begin
      return {i[20] ? 2'b00 : 2'b10, 2'b01};
    end else if (i[27:26] == 2'b10 && i[25]) begin
      return 4'b0110;
    end else begin
      return 4'b0000;
    end
  endfunction

  function automatic stageT retire(stageT s, logic ex);
    stageT r;
    r = s;
    r.regWrite = s.regWrite & ex;
    r.memWrite = s.memWrite & ex;
    r.pcSrc = s.pcSrc & ex;
    return r;
  endfunction

  assign dNow = refDecode(instrD);
  assign exE = condPasses(mE.cond, refFlags);
  assign expBranch = mE.branch & exE;
  assign expLdStall = ldUseMatch & mE.load;
  assign expFlushE = (expLdStall | expBranch) & !memWait;
  assign expStallD = expLdStall | memWait;
  assign expPending = dNow.pcSrc | mE.pcSrc | mM.pcSrc;
  assign expFlushD = (expBranch | expPending) & !expStallD;
  assign expStallF = expLdStall | expPending | memWait;
  assign expAlu = aluExpect(mE, refFlags.c);
  assign expSelD = dSelects(instrD);

  always @(posedge clk) begin
    if (reset) begin
      mE <= '0;
      mM <= '0;
      mW <= '0;
      refFlags <= '0;
    end else if (!memWait) begin  // Memory wait freezes every stage
      mE <= expFlushE ? '0 : dNow;
      mM <= retire(mE, exE);
      mW <= mM;
      if (exE && mE.flagUpd[1]) begin
        refFlags.n <= flagsE.n;
        refFlags.z <= flagsE.z;
      end
      if (exE && mE.flagUpd[0]) begin
        refFlags.c <= flagsE.c;
        refFlags.v <= flagsE.v;
      end
    end
  end

  task automatic noteMismatch(string name, logic [7:0] got, logic [7:0] exp);
    errCount++;
    $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  assert property (@(posedge clk) disable iff (reset) regWriteW == mW.regWrite)
    else noteMismatch("regWriteW", 8'($sampled(regWriteW)), 8'($sampled(mW.regWrite)));
  assert property (@(posedge clk) disable iff (reset) regWriteM == mM.regWrite)
    else noteMismatch("regWriteM", 8'($sampled(regWriteM)), 8'($sampled(mM.regWrite)));
  assert property (@(posedge clk) disable iff (reset) memWriteM == mM.memWrite)
    else noteMismatch("memWriteM", 8'($sampled(memWriteM)), 8'($sampled(mM.memWrite)));
  assert property (@(posedge clk) disable iff (reset) branchTakenE == expBranch)
    else noteMismatch("branchTakenE", 8'($sampled(branchTakenE)), 8'($sampled(expBranch)));
  assert property (@(posedge clk) disable iff (reset) flushE == expFlushE)
    else noteMismatch("flushE", 8'($sampled(flushE)), 8'($sampled(expFlushE)));
  assert property (@(posedge clk) disable iff (reset) stallD == expStallD)
    else noteMismatch("stallD", 8'($sampled(stallD)), 8'($sampled(expStallD)));
  assert property (@(posedge clk) disable iff (reset) flushD == expFlushD)
    else noteMismatch("flushD", 8'($sampled(flushD)), 8'($sampled(expFlushD)));
  assert property (@(posedge clk) disable iff (reset) pcWrPendingF == expPending)
    else noteMismatch("pcWrPendingF", 8'($sampled(pcWrPendingF)), 8'($sampled(expPending)));
  assert property (@(posedge clk) disable iff (reset)
    i_dut.pipeCtrl.condUnit.flagsPrevE == refFlags)
    else noteMismatch("flags", 8'($sampled(i_dut.pipeCtrl.condUnit.flagsPrevE)),
                      8'($sampled(refFlags)));
  assert property (@(posedge clk) disable iff (reset) stallF == expStallF)
    else noteMismatch("stallF", 8'($sampled(stallF)), 8'($sampled(expStallF)));
  assert property (@(posedge clk) disable iff (reset)
    {stallE, stallM, stallW} == {3{memWait}})
    else noteMismatch("stallEMW", 8'($sampled({stallE, stallM, stallW})),
                      8'($sampled({3{memWait}})));
  assert property (@(posedge clk) disable iff (reset) flushW == 1'b0)
    else noteMismatch("flushW", 8'($sampled(flushW)), 8'h0);
  assert property (@(posedge clk) disable iff (reset) aluSrcE == mE.imm)
    else noteMismatch("aluSrcE", 8'($sampled(aluSrcE)), 8'($sampled(mE.imm)));
  assert property (@(posedge clk) disable iff (reset) memtoRegE == mE.load)
    else noteMismatch("memtoRegE", 8'($sampled(memtoRegE)), 8'($sampled(mE.load)));
  assert property (@(posedge clk) disable iff (reset) multEnableE == (mE.mult & exE))
    else noteMismatch("multEnableE", 8'($sampled(multEnableE)), 8'($sampled(mE.mult & exE)));
  assert property (@(posedge clk) disable iff (reset)
    {aluOperationE, invertBE, reverseInputsE, aluCarryE} == expAlu)
    else noteMismatch("aluControlE",
                      8'($sampled({aluOperationE, invertBE, reverseInputsE, aluCarryE})),
                      8'($sampled(expAlu)));
  assert property (@(posedge clk) disable iff (reset) memtoRegM == mM.load)
    else noteMismatch("memtoRegM", 8'($sampled(memtoRegM)), 8'($sampled(mM.load)));
  assert property (@(posedge clk) disable iff (reset) memtoRegW == mW.load)
    else noteMismatch("memtoRegW", 8'($sampled(memtoRegW)), 8'($sampled(mW.load)));
  assert property (@(posedge clk) disable iff (reset) pcSrcW == mW.pcSrc)
    else noteMismatch("pcSrcW", 8'($sampled(pcSrcW)), 8'($sampled(mW.pcSrc)));
  assert property (@(posedge clk) disable iff (reset) {regSrcD, immSrcD} == expSelD)
    else noteMismatch("regSrcImmSrcD", 8'($sampled({regSrcD, immSrcD})), 8'($sampled(expSelD)));

  function automatic logic [3:0] regPick();
    return 4'($urandom % 15);  // r0 to r14
  endfunction

  function automatic instrT dataProc(condT c, aluCtrlT op, logic s);
    return {c, 3'b000, op, s, regPick(), regPick(), 8'h00, regPick()};
  endfunction

  function automatic instrT memOp(condT c, logic load);
    return {c, 3'b010, 4'b1100, load, regPick(), regPick(), 12'($urandom)};
  endfunction

  function automatic instrT mulOp(logic isLong);
    return {condAL, 4'b0000, isLong, 2'b00, 1'b0, regPick(), regPick(), regPick(),
            4'b1001, regPick()};
  endfunction

  task automatic issue(instrT i, flagsT f, logic ld, logic w);
    @(posedge clk);
    instrD <= i;
    flagsE <= f;
    ldUseMatch <= ld;
    memWait <= w;
  endtask

  // Flags land while the setter sits in E
  task automatic issueWithFlags(instrT i, flagsT f);
    issue(i, '0, 1'b0, 1'b0);
    issue(nopInstr, f, 1'b0, 1'b0);
  endtask

  task automatic drain(int n);
    repeat (n) issue(nopInstr, 4'($urandom), 1'b0, 1'b0);
  endtask

  task automatic endTest(string name, int mark);
    @(negedge clk);
    testsRun++;
    if (errCount == mark) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d mismatches", name, errCount - mark);
    end
  endtask

  initial begin
    #(testInstrCount * 10 * 10);
    $display("Timeout: run did not finish within %0d cycles", testInstrCount * 10);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int mark;
    int seedDummy;
    instrT held;
    seedDummy = $urandom(32'h5b69_c7c3);
    reset = 1'b1;
    instrD = nopInstr;
    flagsE = '0;
    ldUseMatch = 1'b0;
    memWait = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    mark = errCount;
    issueWithFlags(dataProc(condAL, ctrlAdd, 1'b1), 4'b0100);  // Z set
    issue(dataProc(condEQ, ctrlAdd, 1'b0), '0, 1'b0, 1'b0);
    drain(4);
    issueWithFlags(dataProc(condAL, ctrlAdd, 1'b1), 4'b0000);
    issue(dataProc(condEQ, ctrlAdd, 1'b0), '0, 1'b0, 1'b0);
    repeat (6) begin
      issueWithFlags(dataProc(condAL, ctrlAdd, 1'b1), 4'($urandom));
      issue(dataProc(condEQ, ctrlOrr, 1'b0), '0, 1'b0, 1'b0);
    end
    drain(4);
    endTest("dataProcFlags", mark);

    mark = errCount;
    issueWithFlags(dataProc(condAL, ctrlSub, 1'b1), 4'b0100);
    issue(memOp(condNE, 1'b0), '0, 1'b0, 1'b0);  // Skipped store
    drain(3);
    issue(memOp(condEQ, 1'b0), '0, 1'b0, 1'b0);
    drain(4);
    endTest("failedCondition", mark);

    mark = errCount;
    issue({condAL, 4'b1010, 24'($urandom)}, '0, 1'b0, 1'b0);
    drain(5);
    issueWithFlags(dataProc(condAL, ctrlAdd, 1'b1), 4'b0000);
    issue({condEQ, 4'b1010, 24'($urandom)}, '0, 1'b0, 1'b0);  // Not taken
    drain(5);
    endTest("branch", mark);

    mark = errCount;
    held = dataProc(condAL, ctrlAdd, 1'b0);
    issue(memOp(condAL, 1'b0), '0, 1'b0, 1'b0);
    issue(dataProc(condAL, ctrlAdd, 1'b1), '0, 1'b0, 1'b0);
    repeat (2 + $urandom % 4) issue(held, 4'($urandom), 1'b0, 1'b1);
    issue(held, 4'b1001, 1'b0, 1'b0);  // Release, D keeps its instruction
    drain(5);
    endTest("memoryWait", mark);

    mark = errCount;
    held = dataProc(condAL, ctrlAdd, 1'b0);
    issue(memOp(condAL, 1'b1), '0, 1'b0, 1'b0);
    issue(held, '0, 1'b1, 1'b0);
    issue(held, '0, 1'b0, 1'b0);  // Stalled D slot again
    drain(2);
    issue(dataProc(condAL, ctrlEor, 1'b0), '0, 1'b0, 1'b0);
    issue(held, '0, 1'b1, 1'b0);  // Match without a load in E
    drain(4);
    endTest("loadUse", mark);

    mark = errCount;
    issueWithFlags({condAL, 3'b000, ctrlCmp, 1'b1, regPick(), 4'd0, 8'h00, regPick()}, 4'b0110);
    drain(3);
    issue(dataProc(condEQ, ctrlMov, 1'b0), '0, 1'b0, 1'b0);
    drain(4);
    endTest("compare", mark);

    mark = errCount;
    for (int k = 0; k < 16; k++) begin
      issueWithFlags(dataProc(condAL, aluCtrlT'(k), 1'b1), 4'($urandom));
    end
    issue({condAL, 3'b001, ctrlMov, 1'b0, 4'd0, regPick(), 12'($urandom)}, '0, 1'b0, 1'b0);
    issue(mulOp(1'b0), '0, 1'b0, 1'b0);
    issue(mulOp(1'b1), '0, 1'b0, 1'b0);  // Long form stays off
    issue({condAL, 4'b1000, 24'($urandom)}, '0, 1'b0, 1'b0);  // Block transfer space
    drain(4);
    endTest("aluOps", mark);

    $display("tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
  import armCtrlPkg::*;

  ctrlBundleT ctrl;         // Control that travels to E
  logic [1:0] regSrc;       // Register read port selects
  logic [1:0] immSrc;       // Immediate extension format
  logic [2:0] multControl;  // Multiply variant from bits 23:21

  modport decoder (
    output ctrl, regSrc, immSrc, multControl
  );

  modport pipeline (
    input ctrl, regSrc, immSrc, multControl
  );

endinterface

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  logic ldUseMatch,
  input  logic memtoRegE,
  input  logic branchTakenE,
  input  logic pcWrPendingF,
  input  logic memWait,
  output logic stallF,
  output logic stallD,
  output logic stallE,
  output logic stallM,
  output logic stallW,
  output logic flushD,
  output logic flushE,
  output logic flushW
);

  always_comb begin
    logic ldStall;

    ldStall = ldUseMatch & memtoRegE;  // Load in E feeds D

    stallF = ldStall | pcWrPendingF | memWait;
    stallD = ldStall | memWait;
    stallE = memWait;  // Whole pipe freezes on memory wait
    stallM = memWait;
    stallW = memWait;

    // A held D slot keeps its instruction
    flushD = (branchTakenE | pcWrPendingF) & ~stallD;
    flushE = (ldStall | branchTakenE) & ~memWait;
    flushW = 1'b0;  // No W-stage flush source in this core

    assert (!(stallD && flushD) && !(stallE && flushE) && !(stallW && flushW))
      else $error("stage stalled and flushed together");
  end

endmodule

// File: mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder (
  input armCtrlPkg::instrT instrD,
  decodeIf.decoder         dec
);
  import armCtrlPkg::*;

  ctrlBundleT ctrl;
  logic [1:0] regSrc;
  logic [1:0] immSrc;
  logic       isDataProc;
  logic       isLoadStore;
  logic [3:0] destReg;

  always_comb begin
    ctrl = '0;
    regSrc = 2'b00;
    immSrc = 2'b00;
    isDataProc = 1'b0;
    isLoadStore = 1'b0;
    case (instrD[27:26])
      2'b00: begin
        isDataProc = 1'b1;
        ctrl.regWrite = 1'b1;
        if (instrD[25]) begin
          ctrl.aluSrc = 1'b1;  // Rotated immediate
        end else if (instrD[7:4] == multPattern) begin
          ctrl.multSelect = 1'b1;
        end
      end
      2'b01: begin
        isLoadStore = 1'b1;
        immSrc = 2'b01;
        ctrl.aluSrc = ~instrD[25];  // Register offset when I is set
        if (instrD[20]) begin
          ctrl.memtoReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end else begin
          regSrc = 2'b10;  // Store data comes from Rd
          ctrl.memWrite = 1'b1;
        end
      end
      2'b10: begin
        // LDM/STM share this space and decode to nothing here
        if (instrD[25]) begin
          regSrc = 2'b01;
          immSrc = 2'b10;
          ctrl.aluSrc = 1'b1;
          ctrl.branch = 1'b1;
        end
      end
      default: ctrl = '0;
    endcase

    ctrl.aluOp = isDataProc | isLoadStore;
    if (isDataProc) begin
      ctrl.aluCtrl = aluCtrlT'(instrD[24:21]);
      ctrl.flagWrite = {2{instrD[20]}};  // S bit
    end else if (isLoadStore && !instrD[23]) begin
      ctrl.aluCtrl = subCtrl;
    end else begin
      ctrl.aluCtrl = addCtrl;  // Up offset and branch target
    end

    // Multiplies name Rd in bits 19:16
    destReg = ctrl.multSelect ? instrD[19:16] : instrD[15:12];
    ctrl.pcSrc = (ctrl.regWrite && destReg == pcReg) || ctrl.branch;
  end

  assign dec.ctrl = ctrl;
  assign dec.regSrc = regSrc;
  assign dec.immSrc = immSrc;
  assign dec.multControl = instrD[23:21];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controllerTb -f src.f -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

// File: src.f
armCtrlPkg.sv
decodeIf.sv
mainDecoder.sv
aluDecoder.sv
conditionUnit.sv
hazardUnit.sv
controller.sv
armControlTop.sv
controllerTb.sv
